// File: rtl/vcoal_defs.svh
`ifndef VCOAL_DEFS_SVH
`define VCOAL_DEFS_SVH

// vector lanes served by one memory operation
`define VCOAL_NUM_LANES 4

// address and data word width
`define VCOAL_WORD_BITS 32

// words per data cache block
`define VCOAL_BLOCK_WORDS 4

// word index bits inside a block
`define VCOAL_BLOCK_BITS 2

`endif

// File: rtl/vcoal_mem_pkg.sv
`include "vcoal_defs.svh"

package vcoal_mem_pkg;

    // one address or data word
    typedef logic [`VCOAL_WORD_BITS-1:0] word_t;

    // block-wide store data, word 0 in the low bits
    typedef logic [`VCOAL_BLOCK_WORDS-1:0][`VCOAL_WORD_BITS-1:0] block_t;

    // one enable per byte of a block, active high
    typedef logic [`VCOAL_BLOCK_WORDS*`VCOAL_WORD_BITS/8-1:0] byte_en_t;

    typedef enum logic [1:0] {
        SEW8  = 2'd0,
        SEW16 = 2'd1,
        SEW32 = 2'd2
    } eew_t;

    // load type handed to the cache for sign handling and extraction
    typedef enum logic [1:0] {
        LB = 2'd0,
        LH = 2'd1,
        LW = 2'd2
    } load_type_t;

endpackage

// File: rtl/vcoal_lane_pkg.sv
`include "vcoal_defs.svh"

package vcoal_lane_pkg;

    // lane number
    typedef logic [$clog2(`VCOAL_NUM_LANES)-1:0] lane_idx_t;

    // one bit per lane, bit 0 is lane 0
    typedef logic [`VCOAL_NUM_LANES-1:0] lane_mask_t;

    // one word per lane, lane 0 in the low bits
    typedef logic [`VCOAL_NUM_LANES-1:0][`VCOAL_WORD_BITS-1:0] lane_words_t;

endpackage

// File: rtl/lane_tracker.sv
`timescale 1ns/10ps

`include "vcoal_defs.svh"

module lane_tracker (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       flush,
    input  logic                       mem_ren,
    input  logic                       mem_wen,
    input  vcoal_lane_pkg::lane_mask_t  lane_mask,
    input  vcoal_lane_pkg::lane_words_t lane_addr,
    input  vcoal_lane_pkg::lane_words_t lane_store_data,
    input  vcoal_lane_pkg::lane_mask_t  group,
    input  logic                       lsc_ready,
    output vcoal_lane_pkg::lane_mask_t  unserved,
    output vcoal_lane_pkg::lane_idx_t   leader,
    output vcoal_mem_pkg::word_t        lsc_addr,
    output vcoal_mem_pkg::word_t        lsc_store_data,
    output logic                       lsc_ren,
    output logic                       lsc_wen,
    output vcoal_lane_pkg::lane_mask_t  lsc_lane_en,
    output logic                       stall
);

    import vcoal_lane_pkg::*;

    lane_mask_t served;
    lane_mask_t next_served;
    logic       mem_op;
    logic       lanes_left;
    logic       req;
    logic       accept;
    logic       last_group;

    // lanes of the current operation still waiting for a request
    assign unserved   = lane_mask & ~served;
    assign lanes_left = |unserved;
    assign mem_op     = mem_ren | mem_wen;

    // lowest unserved lane leads the next group
    always_comb begin
        leader = '0;
        for (int i = `VCOAL_NUM_LANES - 1; i >= 0; i--) begin
            if (unserved[i]) begin
                leader = lane_idx_t'(i);
            end
        end
    end

    assign req    = mem_op & lanes_left;
    assign accept = req & lsc_ready;

    // nothing outside the current group is left after it
    assign last_group = ((unserved & ~group) == '0);

    assign lsc_ren        = mem_ren & lanes_left;
    assign lsc_wen        = mem_wen & lanes_left;
    assign lsc_lane_en    = mem_op ? group : '0;
    assign lsc_addr       = lane_addr[leader];
    assign lsc_store_data = lane_store_data[leader];

    // drops in the cycle the final group is taken so the vector unit moves on
    assign stall = req & ~(accept & last_group);

    always_comb begin
        next_served = served;
        if (!req) begin
            // idle or empty mask, start the next operation clean
            next_served = '0;
        end else if (accept) begin
            if (last_group) begin
                next_served = '0;
            end else begin
                next_served = served | group;
            end
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            served <= '0;
        end else if (flush) begin
            served <= '0;
        end else begin
            served <= next_served;
        end
    end

endmodule

// File: rtl/block_matcher.sv
`timescale 1ns/10ps

`include "vcoal_defs.svh"

module block_matcher (
    input  vcoal_lane_pkg::lane_words_t lane_addr,
    input  vcoal_lane_pkg::lane_mask_t  unserved,
    input  vcoal_lane_pkg::lane_idx_t   leader,
    output vcoal_lane_pkg::lane_mask_t  group
);

    import vcoal_lane_pkg::*;

    // byte offset plus word index sit below the block tag
    localparam int TAG_LSB = `VCOAL_BLOCK_BITS + 2;

    logic [`VCOAL_WORD_BITS-1:TAG_LSB] leader_tag;
    lane_mask_t                        tag_match;

    assign leader_tag = lane_addr[leader][`VCOAL_WORD_BITS-1:TAG_LSB];

    always_comb begin
        tag_match = '0;
        for (int i = 0; i < `VCOAL_NUM_LANES; i++) begin
            tag_match[i] = (lane_addr[i][`VCOAL_WORD_BITS-1:TAG_LSB] == leader_tag);
        end
    end

    // the leader always matches its own tag, so it is in the group while it is unserved
    assign group = tag_match & unserved;

endmodule

// File: rtl/store_merger.sv
`timescale 1ns/10ps

`include "vcoal_defs.svh"

module store_merger (
    input  vcoal_lane_pkg::lane_words_t lane_addr,
    input  vcoal_lane_pkg::lane_words_t lane_store_data,
    input  vcoal_lane_pkg::lane_mask_t  group,
    input  vcoal_mem_pkg::eew_t         eew,
    output vcoal_mem_pkg::block_t       lsc_store_block,
    output vcoal_mem_pkg::byte_en_t     lsc_byte_en,
    output vcoal_mem_pkg::load_type_t   lsc_load_type
);

    import vcoal_mem_pkg::*;

    localparam int BYTES_PER_WORD = `VCOAL_WORD_BITS / 8;
    localparam int HALVES_PER_WORD = BYTES_PER_WORD / 2;

    logic [`VCOAL_BLOCK_BITS-1:0] word_idx;
    logic [1:0]                   byte_off;
    logic [BYTES_PER_WORD-1:0]    lane_be;
    word_t                        lane_word;

    always_comb begin
        lsc_store_block = '0;
        lsc_byte_en     = '0;
        for (int i = 0; i < `VCOAL_NUM_LANES; i++) begin
            word_idx = lane_addr[i][`VCOAL_BLOCK_BITS+1:2];
            byte_off = lane_addr[i][1:0];
            lane_be  = '0;

            // element copied to every slot, enables pick the one it lands in
            case (eew)
                SEW8: begin
                    lane_word         = {BYTES_PER_WORD{lane_store_data[i][7:0]}};
                    lane_be[byte_off] = 1'b1;
                end
                SEW16: begin
                    lane_word = {HALVES_PER_WORD{lane_store_data[i][15:0]}};
                    lane_be[{byte_off[1], 1'b0} +: 2] = 2'b11;
                end
                default: begin
                    lane_word = lane_store_data[i];
                    lane_be   = '1;
                end
            endcase

            if (group[i]) begin
                for (int b = 0; b < BYTES_PER_WORD; b++) begin
                    if (lane_be[b]) begin
                        lsc_store_block[word_idx][b*8 +: 8] = lane_word[b*8 +: 8];
                    end
                end
                lsc_byte_en[word_idx*BYTES_PER_WORD +: BYTES_PER_WORD] =
                    lsc_byte_en[word_idx*BYTES_PER_WORD +: BYTES_PER_WORD] | lane_be;
            end
        end
    end

    always_comb begin
        case (eew)
            SEW8:    lsc_load_type = LB;
            SEW16:   lsc_load_type = LH;
            default: lsc_load_type = LW;
        endcase
    end

endmodule

// File: rtl/vcoal_top.sv
`timescale 1ns/10ps

module vcoal_top (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       flush,
    input  logic                       mem_ren,
    input  logic                       mem_wen,
    input  vcoal_lane_pkg::lane_words_t lane_addr,
    input  vcoal_lane_pkg::lane_mask_t  lane_mask,
    input  vcoal_lane_pkg::lane_words_t lane_store_data,
    input  vcoal_mem_pkg::eew_t         eew,
    input  logic                       lsc_ready,
    output vcoal_mem_pkg::word_t        lsc_addr,
    output logic                       lsc_ren,
    output logic                       lsc_wen,
    output vcoal_lane_pkg::lane_mask_t  lsc_lane_en,
    output vcoal_lane_pkg::lane_idx_t   lsc_curr_lane,
    output vcoal_mem_pkg::word_t        lsc_store_data,
    output vcoal_mem_pkg::block_t       lsc_store_block,
    output vcoal_mem_pkg::byte_en_t     lsc_byte_en,
    output vcoal_mem_pkg::load_type_t   lsc_load_type,
    output logic                       stall
);

    import vcoal_lane_pkg::*;

    lane_mask_t unserved;
    lane_mask_t group;
    lane_idx_t  leader;

    // the leader index is what the cache sees as the current lane
    assign lsc_curr_lane = leader;

    lane_tracker u_lane_tracker (
        .CLK             (CLK),
        .nRST            (nRST),
        .flush           (flush),
        .mem_ren         (mem_ren),
        .mem_wen         (mem_wen),
        .lane_mask       (lane_mask),
        .lane_addr       (lane_addr),
        .lane_store_data (lane_store_data),
        .group           (group),
        .lsc_ready       (lsc_ready),
        .unserved        (unserved),
        .leader          (leader),
        .lsc_addr        (lsc_addr),
        .lsc_store_data  (lsc_store_data),
        .lsc_ren         (lsc_ren),
        .lsc_wen         (lsc_wen),
        .lsc_lane_en     (lsc_lane_en),
        .stall           (stall)
    );

    block_matcher u_block_matcher (
        .lane_addr (lane_addr),
        .unserved  (unserved),
        .leader    (leader),
        .group     (group)
    );

    store_merger u_store_merger (
        .lane_addr       (lane_addr),
        .lane_store_data (lane_store_data),
        .group           (group),
        .eew             (eew),
        .lsc_store_block (lsc_store_block),
        .lsc_byte_en     (lsc_byte_en),
        .lsc_load_type   (lsc_load_type)
    );

endmodule

// File: sim/vcoal_tb_model.svh
`ifndef VCOAL_TB_MODEL_SVH
`define VCOAL_TB_MODEL_SVH

// lanes of the operation not yet taken by an accepted request
function automatic lane_mask_t unserved_lanes(lane_mask_t mask, lane_mask_t served);
    return mask & ~served;
endfunction

function automatic lane_idx_t lowest_lane(lane_mask_t active);
    for (int i = 0; i < `VCOAL_NUM_LANES; i++) begin
        if (active[i]) begin
            return lane_idx_t'(i);
        end
    end
    return '0;
endfunction

// every active lane whose address falls in the leader's block
function automatic lane_mask_t same_block_lanes(lane_words_t addr, lane_mask_t active);
    lane_mask_t grp;
    word_t      lead_block;
    grp = '0;
    lead_block = addr[lowest_lane(active)] >> (`VCOAL_BLOCK_BITS + 2);
    for (int i = 0; i < `VCOAL_NUM_LANES; i++) begin
        if (active[i] && ((addr[i] >> (`VCOAL_BLOCK_BITS + 2)) == lead_block)) begin
            grp[i] = 1'b1;
        end
    end
    return grp;
endfunction

// first byte of the element inside the block
function automatic int element_byte_pos(word_t a, eew_t width);
    case (width)
        SEW8:    return int'(a[3:2]) * 4 + int'(a[1:0]);
        SEW16:   return int'(a[3:2]) * 4 + int'(a[1]) * 2;
        default: return int'(a[3:2]) * 4;
    endcase
endfunction

function automatic int element_size(eew_t width);
    case (width)
        SEW8:    return 1;
        SEW16:   return 2;
        default: return 4;
    endcase
endfunction

// higher lanes land on top of lower ones when they hit the same byte
function automatic block_t merged_block(lane_words_t addr, lane_words_t data,
                                        lane_mask_t grp, eew_t width);
    logic [`VCOAL_BLOCK_WORDS*`VCOAL_WORD_BITS-1:0] flat;
    int                                             pos;
    flat = '0;
    for (int i = 0; i < `VCOAL_NUM_LANES; i++) begin
        if (grp[i]) begin
            pos = element_byte_pos(addr[i], width);
            for (int b = 0; b < element_size(width); b++) begin
                flat[(pos + b)*8 +: 8] = data[i][b*8 +: 8];
            end
        end
    end
    return flat;
endfunction

function automatic byte_en_t byte_enables(lane_words_t addr, lane_mask_t grp, eew_t width);
    byte_en_t en;
    int       pos;
    en = '0;
    for (int i = 0; i < `VCOAL_NUM_LANES; i++) begin
        if (grp[i]) begin
            pos = element_byte_pos(addr[i], width);
            for (int b = 0; b < element_size(width); b++) begin
                en[pos + b] = 1'b1;
            end
        end
    end
    return en;
endfunction

function automatic load_type_t load_type_for(eew_t width);
    case (width)
        SEW8:    return LB;
        SEW16:   return LH;
        default: return LW;
    endcase
endfunction

`endif

// File: sim/vcoal_tb.sv
`timescale 1ns/10ps

`include "vcoal_defs.svh"

module vcoal_tb;

    import vcoal_mem_pkg::*;
    import vcoal_lane_pkg::*;

    `include "vcoal_tb_model.svh"

    localparam int PERIOD       = 40;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_OPS      = 400;
    // four groups of up to four cycles each, plus flush and idle cycles
    localparam int OP_CYCLES    = 24;
    localparam int TIMEOUT      = (RESET_CYCLES + NUM_OPS * OP_CYCLES + 100) * PERIOD;

    logic        CLK;
    logic        nRST;
    logic        flush;
    logic        mem_ren;
    logic        mem_wen;
    lane_words_t lane_addr;
    lane_mask_t  lane_mask;
    lane_words_t lane_store_data;
    eew_t        eew;
    logic        lsc_ready;
    word_t       lsc_addr;
    logic        lsc_ren;
    logic        lsc_wen;
    lane_mask_t  lsc_lane_en;
    lane_idx_t   lsc_curr_lane;
    word_t       lsc_store_data;
    block_t      lsc_store_block;
    byte_en_t    lsc_byte_en;
    load_type_t  lsc_load_type;
    logic        stall;

    integer     seed;
    int         error_count;
    int         check_count;
    int         ready_low_run;
    lane_mask_t tb_served;

    vcoal_top dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .flush           (flush),
        .mem_ren         (mem_ren),
        .mem_wen         (mem_wen),
        .lane_addr       (lane_addr),
        .lane_mask       (lane_mask),
        .lane_store_data (lane_store_data),
        .eew             (eew),
        .lsc_ready       (lsc_ready),
        .lsc_addr        (lsc_addr),
        .lsc_ren         (lsc_ren),
        .lsc_wen         (lsc_wen),
        .lsc_lane_en     (lsc_lane_en),
        .lsc_curr_lane   (lsc_curr_lane),
        .lsc_store_data  (lsc_store_data),
        .lsc_store_block (lsc_store_block),
        .lsc_byte_en     (lsc_byte_en),
        .lsc_load_type   (lsc_load_type),
        .stall           (stall)
    );

    always #(PERIOD/2) CLK = ~CLK;

    task automatic check_value(string name, logic [127:0] expected, logic [127:0] actual);
        check_count++;
        assert (expected === actual) else begin
            error_count++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic flag_failure(string what);
        error_count++;
        $display("ERROR: %s", what);
    endtask

    // cache is never busy for more than three cycles in a row
    task automatic pick_ready();
        if (ready_low_run >= 3) begin
            lsc_ready = 1'b1;
        end else begin
            lsc_ready = (($random(seed) & 3) != 0);
        end
        ready_low_run = lsc_ready ? 0 : ready_low_run + 1;
    endtask

    task automatic idle_cycle(string name);
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        pick_ready();
        #(PERIOD/4);
        check_value({name, " stall"}, 1'b0, stall);
        check_value({name, " lsc_ren"}, 1'b0, lsc_ren);
        check_value({name, " lsc_wen"}, 1'b0, lsc_wen);
        tb_served = '0;
        @(negedge CLK);
    endtask

    task automatic make_operation();
        word_t      base;
        word_t      far;
        word_t      addr;
        logic [1:0] off;
        int         sel;
        base = $random(seed);
        base[3:0] = 4'h0;
        mem_ren = (($random(seed) & 1) != 0);
        mem_wen = !mem_ren;
        sel = $random(seed) & 3;
        if (sel == 3) begin
            sel = 2;
        end
        eew = eew_t'(sel);
        lane_mask = lane_mask_t'($random(seed));
        for (int i = 0; i < `VCOAL_NUM_LANES; i++) begin
            off = 2'($random(seed));
            if (eew == SEW16) begin
                off[0] = 1'b0;
            end else if (eew == SEW32) begin
                off = 2'b00;
            end
            // most lanes land in one of two neighbouring blocks
            addr = base + (($random(seed) & 1) * 16) + (($random(seed) & 3) * 4) + off;
            if (($random(seed) & 7) == 0) begin
                far = $random(seed);
                addr[31:4] = far[27:0];
            end
            lane_addr[i] = addr;
            lane_store_data[i] = $random(seed);
        end
    endtask

    task automatic run_operation(int op_num);
        lane_mask_t active;
        lane_mask_t grp;
        lane_mask_t op_served;
        lane_mask_t held_en;
        lane_idx_t  lead;
        word_t      held_addr;
        logic       req;
        logic       accept;
        logic       last;
        logic       held;
        logic       done;
        logic       do_flush;
        logic       flushing;
        string      tag;
        int         cycle;
        make_operation();
        do_flush = (($random(seed) & 15) == 0);
        op_served = '0;
        held = 1'b0;
        done = 1'b0;
        cycle = 0;
        while (!done) begin
            tag = $sformatf("op %0d cycle %0d", op_num, cycle);
            active = unserved_lanes(lane_mask, tb_served);
            lead = lowest_lane(active);
            grp = same_block_lanes(lane_addr, active);
            req = (mem_ren || mem_wen) && (active != '0);
            last = ((active & ~grp) == '0);
            flushing = do_flush && (cycle == 1);
            flush = flushing;
            if (flushing) begin
                lsc_ready = 1'b0;
            end else begin
                pick_ready();
            end
            accept = req && lsc_ready;
            #(PERIOD/4);
            check_value({tag, " lsc_ren"}, mem_ren && (active != '0), lsc_ren);
            check_value({tag, " lsc_wen"}, mem_wen && (active != '0), lsc_wen);
            check_value({tag, " stall"}, req && !(accept && last), stall);
            if (req) begin
                check_value({tag, " lsc_lane_en"}, grp, lsc_lane_en);
                check_value({tag, " lsc_curr_lane"}, lead, lsc_curr_lane);
                check_value({tag, " lsc_addr"}, lane_addr[lead], lsc_addr);
                check_value({tag, " lsc_store_data"}, lane_store_data[lead], lsc_store_data);
                check_value({tag, " lsc_load_type"}, load_type_for(eew), lsc_load_type);
                if (mem_wen) begin
                    check_value({tag, " lsc_store_block"},
                                merged_block(lane_addr, lane_store_data, grp, eew),
                                lsc_store_block);
                    check_value({tag, " lsc_byte_en"},
                                byte_enables(lane_addr, grp, eew), lsc_byte_en);
                end
                // a request the cache did not take must come back unchanged
                if (held) begin
                    check_value({tag, " held lsc_addr"}, held_addr, lsc_addr);
                    check_value({tag, " held lsc_lane_en"}, held_en, lsc_lane_en);
                end
            end
            if (accept) begin
                assert ((op_served & lsc_lane_en) == '0) else begin
                    flag_failure($sformatf("%s: a lane was served twice in one operation", tag));
                end
                op_served = op_served | lsc_lane_en;
                tb_served = last ? '0 : (tb_served | grp);
            end
            held = req && !accept;
            held_addr = lsc_addr;
            held_en = lsc_lane_en;
            if (!req || flushing) begin
                tb_served = '0;
            end
            done = !req || (accept && last) || flushing;
            if (done && !flushing) begin
                check_value({tag, " served lanes"}, lane_mask, op_served);
            end
            cycle++;
            @(negedge CLK);
            flush = 1'b0;
        end
    endtask

    initial begin
        seed = 45200;
        error_count = 0;
        check_count = 0;
        ready_low_run = 0;
        tb_served = '0;
        CLK = 1'b0;
        nRST = 1'b0;
        flush = 1'b0;
        mem_ren = 1'b0;
        mem_wen = 1'b0;
        lane_addr = '0;
        lane_mask = '0;
        lane_store_data = '0;
        eew = SEW8;
        lsc_ready = 1'b0;
        repeat (RESET_CYCLES) @(negedge CLK);
        nRST = 1'b1;
        idle_cycle("after reset");
        for (int n = 0; n < NUM_OPS; n++) begin
            run_operation(n);
            if (($random(seed) & 1) != 0) begin
                idle_cycle($sformatf("idle after op %0d", n));
            end
        end
        $display("errors: %0d in %0d checks", error_count, check_count);
        if (error_count == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // ends a run whose operations never complete
    initial begin
        #(TIMEOUT);
        $display("ERROR: timed out before all operations completed, the run hung");
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: vcoal.f
+incdir+rtl
+incdir+sim
rtl/vcoal_mem_pkg.sv
rtl/vcoal_lane_pkg.sv
rtl/lane_tracker.sv
rtl/block_matcher.sv
rtl/store_merger.sv
rtl/vcoal_top.sv
sim/vcoal_tb.sv
